//--- verilog/ICachePkg.sv
`default_nettype none

package ICachePkg;

    // Cache geometry
    localparam int NUM_WAYS = 2;
    localparam int NUM_SETS = 64;
    localparam int LINE_WORDS = 4;

    localparam int FIFO_DEPTH = 4;

    // First physical address outside the fetchable region
    localparam logic [31:0] LEGAL_LIMIT = 32'h0010_0000;

    // PC field boundaries
    localparam int SET_LSB = 4;
    localparam int TAG_LSB = 10;

    typedef logic [31:0] Pc_t;

    typedef logic [31:TAG_LSB] Tag_t;

    typedef logic [TAG_LSB-SET_LSB-1:0] SetIdx_t;

    typedef logic [$clog2(NUM_WAYS)-1:0] Way_t;

    // Four instruction words with word 0 in the low bits
    typedef logic [LINE_WORDS*32-1:0] Block_t;

    typedef logic [4:0] FetchId_t;

    typedef logic [$clog2(FIFO_DEPTH):0] FifoCount_t;

    typedef enum logic [1:0] {
        FAULT_NONE,
        FAULT_ACCESS
    } FetchFault_t;

    typedef enum logic [1:0] {
        FLUSH_IDLE,
        FLUSH_QUEUED,
        FLUSH_ACTIVE,
        FLUSH_FINALIZE
    } FlushState_t;

endpackage

`default_nettype wire

//--- verilog/ICacheRamIf.sv
`timescale 1ns/1ns
`default_nettype none

interface ICacheRamIf;
    import ICachePkg::*;

    // Read data returns one cycle after readEnable
    logic readEnable;
    SetIdx_t readSet;
    logic [NUM_WAYS-1:0] readValid;
    Tag_t readTag [NUM_WAYS];
    Block_t readBlock [NUM_WAYS];

    // Write port
    logic writeEnable;
    Way_t writeWay;
    SetIdx_t writeSet;
    logic writeValid;
    Tag_t writeTag;

    modport host (
        output readEnable, readSet,
        output writeEnable, writeWay, writeSet, writeValid, writeTag,
        input readValid, readTag, readBlock
    );

    modport ram (
        input readEnable, readSet,
        input writeEnable, writeWay, writeSet, writeValid, writeTag,
        output readValid, readTag, readBlock
    );

endinterface

`default_nettype wire

//--- verilog/ICacheTagRam.sv
`timescale 1ns/1ns
`default_nettype none

module ICacheTagRam (
    input logic clk,
    input logic rst,
    ICacheRamIf.ram bus
);
    import ICachePkg::*;

    logic [NUM_WAYS-1:0] validArr [NUM_SETS];
    Tag_t tagArr [NUM_WAYS][NUM_SETS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                validArr[s] <= '0;
            end
        end else if (bus.writeEnable) begin
            validArr[bus.writeSet][bus.writeWay] <= bus.writeValid;
        end
        if (bus.writeEnable) begin
            tagArr[bus.writeWay][bus.writeSet] <= bus.writeTag;
        end
    end

    // Both ways come back together
    always_ff @(posedge clk) begin
        if (rst) begin
            bus.readValid <= '0;
        end else if (bus.readEnable) begin
            bus.readValid <= validArr[bus.readSet];
        end
        if (bus.readEnable) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                bus.readTag[w] <= tagArr[w][bus.readSet];
            end
        end
    end

    // No block storage here
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            bus.readBlock[w] = '0;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        bus.writeEnable |-> !$isunknown({bus.writeWay, bus.writeSet}));

endmodule

`default_nettype wire

//--- verilog/ICacheDataRam.sv
`timescale 1ns/1ns
`default_nettype none

module ICacheDataRam (
    input logic clk,
    ICacheRamIf.ram bus,
    input logic fillWe,
    input ICachePkg::Way_t fillWay,
    input ICachePkg::SetIdx_t fillSet,
    input logic [1:0] fillWord,
    input logic [31:0] fillData
);
    import ICachePkg::*;

    Block_t blockArr [NUM_WAYS][NUM_SETS];

    // Line fill writes one word per cycle
    always_ff @(posedge clk) begin
        if (fillWe) begin
            blockArr[fillWay][fillSet][{fillWord, 5'b0} +: 32] <= fillData;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.readEnable) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                bus.readBlock[w] <= blockArr[w][bus.readSet];
            end
        end
    end

    // Tags live in the tag RAM
    always_comb begin
        bus.readValid = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            bus.readTag[w] = '0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/FetchFifo.sv
`timescale 1ns/1ns
`default_nettype none

module FetchFifo (
    input logic clk,
    input logic rst,
    input logic inValid,
    input ICachePkg::Pc_t inPc,
    input ICachePkg::Block_t inData,
    input ICachePkg::FetchFault_t inFault,
    input ICachePkg::FetchId_t inId,
    output ICachePkg::FifoCount_t free,
    output logic outValid,
    input logic outReady,
    output ICachePkg::Pc_t outPc,
    output ICachePkg::Block_t outData,
    output ICachePkg::FetchFault_t outFault,
    output ICachePkg::FetchId_t outId
);
    import ICachePkg::*;

    Pc_t pcMem [FIFO_DEPTH];
    Block_t dataMem [FIFO_DEPTH];
    FetchFault_t faultMem [FIFO_DEPTH];
    FetchId_t idMem [FIFO_DEPTH];

    logic [$clog2(FIFO_DEPTH)-1:0] rdPtr;
    logic [$clog2(FIFO_DEPTH)-1:0] wrPtr;
    FifoCount_t count;
    logic doRead;

    assign doRead = outValid && outReady;
    assign outValid = count != '0;
    assign free = FifoCount_t'(FIFO_DEPTH) - count;

    assign outPc = pcMem[rdPtr];
    assign outData = dataMem[rdPtr];
    assign outFault = faultMem[rdPtr];
    assign outId = idMem[rdPtr];

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (inValid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + FifoCount_t'(inValid) - FifoCount_t'(doRead);
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            pcMem[wrPtr] <= inPc;
            dataMem[wrPtr] <= inData;
            faultMem[wrPtr] <= inFault;
            idMem[wrPtr] <= inId;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        inValid |-> count != FifoCount_t'(FIFO_DEPTH));

endmodule

`default_nettype wire

//--- verilog/ICacheTable.sv
`timescale 1ns/1ns
`default_nettype none

module ICacheTable (
    input logic clk,
    input logic rst,
    input logic fetchValid,
    input ICachePkg::Pc_t fetchPc,
    output logic stall,
    input logic mispredict,
    input ICachePkg::FetchId_t mispredictId,
    input ICachePkg::FetchId_t oldestId,
    input logic clearCache,
    input logic memBusy,
    input logic fillDone,
    output logic missValid,
    output ICachePkg::Pc_t missPc,
    output ICachePkg::FetchId_t missId,
    output logic memReqValid,
    output ICachePkg::Pc_t memReqAddr,
    output ICachePkg::Way_t memReqWay,
    output ICachePkg::SetIdx_t memReqSet,
    ICacheRamIf.host tagBus,
    ICacheRamIf.host dataBus,
    input ICachePkg::FifoCount_t fifoFree,
    output logic pktValid,
    output ICachePkg::Pc_t pktPc,
    output ICachePkg::Block_t pktData,
    output ICachePkg::FetchFault_t pktFault,
    output ICachePkg::FetchId_t pktId
);
    import ICachePkg::*;

    logic s0Valid;
    logic s1Valid;
    Pc_t s0Pc;
    Pc_t s1Pc;
    FetchId_t s0Id;
    FetchId_t s1Id;
    FetchId_t fetchId;
    logic accept;

    Tag_t s1Tag;
    SetIdx_t s1Set;
    logic [NUM_WAYS-1:0] wayMatch;
    Way_t hitWay;
    logic isFault;
    logic isHit;
    logic pendingHere;
    logic loadMiss;

    logic pendingValid;
    Tag_t pendingTag;
    SetIdx_t pendingSet;
    Way_t wayCnt;

    FlushState_t flushState;
    logic [$bits(Way_t)+$bits(SetIdx_t)-1:0] flushIdx;
    Way_t flushWay;
    SetIdx_t flushSet;

    assign {flushWay, flushSet} = flushIdx;

    always_comb begin
        stall = 1'b0;
        // Keep one FIFO slot for every block still in flight
        if (fifoFree <= FifoCount_t'(s0Valid) + FifoCount_t'(s1Valid)) begin
            stall = 1'b1;
        end
        if (fetchId == oldestId) begin
            stall = 1'b1;
        end
        if (flushState != FLUSH_IDLE) begin
            stall = 1'b1;
        end
        if (pendingValid || memReqValid) begin
            stall = 1'b1;
        end
    end

    assign accept = fetchValid && !stall;

    // Both RAMs are read while the request sits in stage 0
    assign tagBus.readEnable = s0Valid;
    assign tagBus.readSet = s0Pc[TAG_LSB-1:SET_LSB];
    assign dataBus.readEnable = s0Valid;
    assign dataBus.readSet = s0Pc[TAG_LSB-1:SET_LSB];

    assign dataBus.writeEnable = 1'b0;
    assign dataBus.writeWay = '0;
    assign dataBus.writeSet = '0;
    assign dataBus.writeValid = 1'b0;
    assign dataBus.writeTag = '0;

    assign s1Tag = s1Pc[31:TAG_LSB];
    assign s1Set = s1Pc[TAG_LSB-1:SET_LSB];

    always_comb begin
        hitWay = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            wayMatch[w] = tagBus.readValid[w] && tagBus.readTag[w] == s1Tag;
            if (wayMatch[w]) begin
                hitWay = Way_t'(w);
            end
        end
    end

    assign pendingHere = pendingValid && pendingTag == s1Tag && pendingSet == s1Set;
    assign isFault = s1Pc >= LEGAL_LIMIT;
    assign isHit = (|wayMatch) && !pendingHere;

    assign missValid = s1Valid && !mispredict && !isFault && !isHit;
    assign missPc = s1Pc;
    assign missId = s1Id;
    assign loadMiss = missValid && !pendingHere;

    assign pktValid = s1Valid && !mispredict && (isFault || isHit);
    assign pktPc = s1Pc;
    assign pktId = s1Id;
    assign pktFault = isFault ? FAULT_ACCESS : FAULT_NONE;
    assign pktData = isFault ? '0 : dataBus.readBlock[hitWay];

    always_comb begin
        tagBus.writeEnable = loadMiss;
        tagBus.writeWay = wayCnt;
        tagBus.writeSet = s1Set;
        tagBus.writeValid = 1'b1;
        tagBus.writeTag = s1Tag;
        if (flushState == FLUSH_ACTIVE) begin
            tagBus.writeEnable = 1'b1;
            tagBus.writeWay = flushWay;
            tagBus.writeSet = flushSet;
            tagBus.writeValid = 1'b0;
            tagBus.writeTag = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s0Valid <= 1'b0;
            s1Valid <= 1'b0;
            fetchId <= '0;
        end else if (mispredict) begin
            s0Valid <= 1'b0;
            s1Valid <= 1'b0;
            fetchId <= mispredictId + FetchId_t'(1);
        end else if (missValid) begin
            // Squash and replay from the missed block
            s0Valid <= 1'b0;
            s1Valid <= 1'b0;
            fetchId <= s1Id;
        end else begin
            s0Valid <= accept;
            s1Valid <= s0Valid;
            if (accept) begin
                fetchId <= fetchId + FetchId_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        s0Pc <= fetchPc;
        s0Id <= fetchId;
        s1Pc <= s0Pc;
        s1Id <= s0Id;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pendingValid <= 1'b0;
            wayCnt <= '0;
            memReqValid <= 1'b0;
        end else begin
            if (loadMiss) begin
                pendingValid <= 1'b1;
                wayCnt <= wayCnt + 1'b1;
            end else if (fillDone) begin
                pendingValid <= 1'b0;
            end
            if (loadMiss) begin
                memReqValid <= 1'b1;
            end else if (!memBusy) begin
                memReqValid <= 1'b0;
            end
        end
        if (loadMiss) begin
            pendingTag <= s1Tag;
            pendingSet <= s1Set;
            memReqAddr <= {s1Pc[31:SET_LSB], {SET_LSB{1'b0}}};
            memReqWay <= wayCnt;
            memReqSet <= s1Set;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flushState <= FLUSH_QUEUED;
            flushIdx <= '0;
        end else begin
            case (flushState)
                FLUSH_IDLE: begin
                    if (clearCache) begin
                        flushState <= FLUSH_QUEUED;
                    end
                end
                FLUSH_QUEUED: begin
                    flushIdx <= '0;
                    if (!s0Valid && !s1Valid) begin
                        flushState <= FLUSH_ACTIVE;
                    end
                end
                FLUSH_ACTIVE: begin
                    flushIdx <= flushIdx + 1'b1;
                    if (&flushIdx) begin
                        flushState <= memBusy ? FLUSH_FINALIZE : FLUSH_IDLE;
                    end
                end
                default: begin
                    if (!memBusy) begin
                        flushState <= FLUSH_IDLE;
                    end
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        s1Valid |-> $onehot0(wayMatch));

    // The room check at accept time must cover every packet
    assert property (@(posedge clk) disable iff (rst)
        pktValid |-> fifoFree != '0);

endmodule

`default_nettype wire

//--- verilog/ICacheTop.sv
`timescale 1ns/1ns
`default_nettype none

module ICacheTop (
    input logic clk,
    input logic rst,
    input logic fetchValid,
    input ICachePkg::Pc_t fetchPc,
    output logic stall,
    input logic mispredict,
    input ICachePkg::FetchId_t mispredictId,
    input ICachePkg::FetchId_t oldestId,
    input logic clearCache,
    output logic missValid,
    output ICachePkg::Pc_t missPc,
    output ICachePkg::FetchId_t missId,
    output logic memReqValid,
    output ICachePkg::Pc_t memReqAddr,
    output ICachePkg::Way_t memReqWay,
    output ICachePkg::SetIdx_t memReqSet,
    input logic memBusy,
    input logic fillWe,
    input ICachePkg::Way_t fillWay,
    input ICachePkg::SetIdx_t fillSet,
    input logic [1:0] fillWord,
    input logic [31:0] fillData,
    input logic fillDone,
    output logic outValid,
    output ICachePkg::Pc_t outPc,
    output ICachePkg::Block_t outData,
    output ICachePkg::FetchFault_t outFault,
    output ICachePkg::FetchId_t outId,
    input logic outReady
);
    import ICachePkg::*;

    FifoCount_t fifoFree;
    logic pktValid;
    Pc_t pktPc;
    Block_t pktData;
    FetchFault_t pktFault;
    FetchId_t pktId;

    ICacheRamIf tagBus();
    ICacheRamIf dataBus();

    ICacheTable table0 (
        .clk(clk), .rst(rst), .fetchValid(fetchValid), .fetchPc(fetchPc), .stall(stall),
        .mispredict(mispredict), .mispredictId(mispredictId), .oldestId(oldestId),
        .clearCache(clearCache), .memBusy(memBusy), .fillDone(fillDone),
        .missValid(missValid), .missPc(missPc), .missId(missId),
        .memReqValid(memReqValid), .memReqAddr(memReqAddr), .memReqWay(memReqWay),
        .memReqSet(memReqSet), .tagBus(tagBus.host), .dataBus(dataBus.host),
        .fifoFree(fifoFree), .pktValid(pktValid), .pktPc(pktPc), .pktData(pktData),
        .pktFault(pktFault), .pktId(pktId)
    );

    ICacheTagRam tagRam0 (.clk(clk), .rst(rst), .bus(tagBus.ram));

    ICacheDataRam dataRam0 (
        .clk(clk), .bus(dataBus.ram), .fillWe(fillWe), .fillWay(fillWay),
        .fillSet(fillSet), .fillWord(fillWord), .fillData(fillData)
    );

    // Queued packets are younger than a mispredict and are dropped with it
    FetchFifo fifo0 (
        .clk(clk), .rst(rst || mispredict), .inValid(pktValid), .inPc(pktPc),
        .inData(pktData), .inFault(pktFault), .inId(pktId), .free(fifoFree),
        .outValid(outValid), .outReady(outReady), .outPc(outPc), .outData(outData),
        .outFault(outFault), .outId(outId)
    );

endmodule

`default_nettype wire

//--- testbench/ICacheTb.sv
`timescale 1ns/1ns
`default_nettype none

module ICacheTb;
    import ICachePkg::*;

    localparam int TIMEOUT = 400;
    localparam int MAX_ENTRIES = 20;

    logic clk, rst, fetchValid, stall, mispredict, clearCache;
    logic missValid, memReqValid, memBusy, fillWe, fillDone, outValid, outReady;
    Pc_t fetchPc, missPc, memReqAddr, outPc;
    FetchId_t mispredictId, oldestId, missId, outId;
    Way_t memReqWay, fillWay;
    SetIdx_t memReqSet, fillSet;
    logic [1:0] fillWord;
    logic [31:0] fillData;
    Block_t outData;
    FetchFault_t outFault;

    // Stimulus table
    Pc_t tblPc [MAX_ENTRIES];
    logic tblClr [MAX_ENTRIES];
    logic tblHold [MAX_ENTRIES];
    logic tblMisp [MAX_ENTRIES];
    FetchId_t tblMispId [MAX_ENTRIES];
    int numEntries;

    // Reference cache model
    logic refValid [NUM_WAYS][NUM_SETS];
    Tag_t refTag [NUM_WAYS][NUM_SETS];
    Way_t refRr;
    FetchId_t nextId;

    int errors;
    int failures;

    ICacheTop dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task finishRun;
        $display("Summary: %0d value errors, %0d other failures", errors, failures);
        if (errors == 0 && failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task abortRun(input string what);
        $display("%s", what);
        failures++;
        finishRun();
    endtask

    task checkField(input string name, input logic [127:0] got, input logic [127:0] exp);
        assert (got === exp) else begin
            $display("error %s expected %0h got %0h", name, exp, got);
            errors++;
        end
    endtask

    task expectTrue(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("%s", what);
            failures++;
        end
    endtask

    task addEntry(input Pc_t pc, input logic clr, input logic hold, input logic misp,
                  input FetchId_t mispId);
        tblPc[numEntries] = pc;
        tblClr[numEntries] = clr;
        tblHold[numEntries] = hold;
        tblMisp[numEntries] = misp;
        tblMispId[numEntries] = mispId;
        numEntries++;
    endtask

    task clearModel;
        for (int w = 0; w < NUM_WAYS; w++) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                refValid[w][s] = 1'b0;
                refTag[w][s] = '0;
            end
        end
    endtask

    function int findWay(input Pc_t pc);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (refValid[w][pc[9:4]] && refTag[w][pc[9:4]] == pc[31:10]) begin
                return w;
            end
        end
        return -1;
    endfunction

    // Memory contents are the word address XOR a fixed pattern
    function Block_t lineData(input Pc_t pc);
        Block_t blk;
        Pc_t base;
        base = {pc[31:4], 4'h0};
        for (int i = 0; i < LINE_WORDS; i++) begin
            blk[i*32 +: 32] = (base + 32'(4 * i)) ^ 32'h5a5a_0000;
        end
        return blk;
    endfunction

    task issueBlock(input Pc_t pc);
        int n;
        n = 0;
        while (stall && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (stall) begin
            abortRun("timed out waiting for stall to fall");
        end else begin
            fetchValid = 1'b1;
            fetchPc = pc;
            @(negedge clk);
            fetchValid = 1'b0;
        end
    endtask

    // Consumes the FIFO head, which pops at the next rising edge
    task takePacket(input Pc_t pc, input logic fault);
        int n;
        n = 0;
        while (!outValid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!outValid) begin
            abortRun("timed out waiting for outValid");
        end else begin
            checkField("outPc", outPc, pc);
            checkField("outFault", outFault, fault ? FAULT_ACCESS : FAULT_NONE);
            checkField("outData", outData, fault ? Block_t'(0) : lineData(pc));
            checkField("outId", outId, nextId);
            nextId = nextId + 1'b1;
            oldestId = nextId - 1'b1;
            @(negedge clk);
        end
    endtask

    task runSingle(input Pc_t pc);
        int n;
        int way;
        logic done;
        done = 1'b0;
        while (!done) begin
            way = findWay(pc);
            issueBlock(pc);
            n = 0;
            while (!outValid && !missValid && n < TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            if (!outValid && !missValid) begin
                abortRun("timed out waiting for a packet or a miss");
            end else if (pc >= LEGAL_LIMIT || way >= 0) begin
                if (missValid) begin
                    abortRun($sformatf("miss on block %h that should hit or fault", pc));
                end else begin
                    takePacket(pc, pc >= LEGAL_LIMIT);
                    expectTrue(!memReqValid, "memory request raised without a miss");
                    done = 1'b1;
                end
            end else if (!missValid) begin
                abortRun($sformatf("packet delivered for block %h that should miss", pc));
            end else begin
                checkField("missPc", missPc, pc);
                checkField("missId", missId, nextId);
                n = 0;
                while (!memReqValid && n < TIMEOUT) begin
                    @(negedge clk);
                    n++;
                end
                if (!memReqValid) begin
                    abortRun("timed out waiting for memReqValid");
                end else begin
                    checkField("memReqAddr", memReqAddr, {pc[31:4], 4'h0});
                    checkField("memReqWay", memReqWay, refRr);
                    checkField("memReqSet", memReqSet, pc[9:4]);
                    refValid[refRr][pc[9:4]] = 1'b1;
                    refTag[refRr][pc[9:4]] = pc[31:10];
                    refRr = refRr + 1'b1;
                end
            end
        end
    endtask

    // Four hits with the consumer stopped, then drained in order
    task runBurst(input Pc_t pc);
        Pc_t bpc [4];
        outReady = 1'b0;
        for (int k = 0; k < 4; k++) begin
            bpc[k] = pc + 32'(16 * (k % 2));
            if (findWay(bpc[k]) < 0) begin
                abortRun($sformatf("burst block %h is not cached", bpc[k]));
            end else begin
                issueBlock(bpc[k]);
            end
        end
        repeat (3) @(negedge clk);
        expectTrue(stall, "stall low while the FIFO is full and outReady is low");
        outReady = 1'b1;
        for (int k = 0; k < 4; k++) begin
            takePacket(bpc[k], 1'b0);
        end
    endtask

    task runMispredict(input Pc_t pc, input FetchId_t mid);
        issueBlock(pc);
        mispredict = 1'b1;
        mispredictId = mid;
        oldestId = mid;
        @(negedge clk);
        mispredict = 1'b0;
        repeat (6) begin
            @(negedge clk);
            expectTrue(!outValid && !missValid && !memReqValid,
                "squashed block came out after a mispredict");
        end
        nextId = mid + 1'b1;
    endtask

    task runClear;
        clearCache = 1'b1;
        @(negedge clk);
        clearCache = 1'b0;
        expectTrue(stall, "stall low after a clearCache pulse");
        clearModel();
    endtask

    task checkResetFlush;
        int n;
        n = 0;
        while (stall && n < TIMEOUT) begin
            expectTrue(!memReqValid && !missValid && !outValid,
                "output active during the reset flush");
            @(negedge clk);
            n++;
        end
        if (stall) begin
            abortRun("timed out waiting for the reset flush");
        end else begin
            expectTrue(n == 129, $sformatf("reset flush took %0d cycles instead of 129", n));
        end
    endtask

    // Memory controller model
    initial begin
        Pc_t reqAddr;
        Way_t reqWay;
        SetIdx_t reqSet;
        int delay;
        int unsigned seedVal;
        memBusy = 1'b0;
        fillWe = 1'b0;
        fillWay = '0;
        fillSet = '0;
        fillWord = '0;
        fillData = '0;
        fillDone = 1'b0;
        seedVal = 32'hcd1ad9cf;
        void'($urandom(seedVal));
        forever begin
            @(negedge clk);
            if (memReqValid && !rst) begin
                memBusy = 1'b1;
                reqAddr = memReqAddr;
                reqWay = memReqWay;
                reqSet = memReqSet;
                delay = 1 + $urandom % 4;
                repeat (delay) @(negedge clk);
                for (int i = 0; i < LINE_WORDS; i++) begin
                    fillWe = 1'b1;
                    fillWay = reqWay;
                    fillSet = reqSet;
                    fillWord = 2'(i);
                    fillData = (reqAddr + 32'(4 * i)) ^ 32'h5a5a_0000;
                    @(negedge clk);
                end
                fillWe = 1'b0;
                fillDone = 1'b1;
                memBusy = 1'b0;
                @(negedge clk);
                fillDone = 1'b0;
            end
        end
    end

    initial begin
        rst = 1'b1;
        fetchValid = 1'b0;
        fetchPc = '0;
        mispredict = 1'b0;
        mispredictId = '0;
        oldestId = 5'h1f;
        clearCache = 1'b0;
        outReady = 1'b1;
        errors = 0;
        failures = 0;
        nextId = '0;
        refRr = '0;
        numEntries = 0;
        clearModel();

        // Set 4 conflicts exercise the round-robin eviction
        addEntry(32'h0000_1040, 1'b0, 1'b0, 1'b0, 5'd0);
        addEntry(32'h0000_1040, 1'b0, 1'b0, 1'b0, 5'd0);
        addEntry(32'h0000_2040, 1'b0, 1'b0, 1'b0, 5'd0);
        addEntry(32'h0000_3040, 1'b0, 1'b0, 1'b0, 5'd0);
        addEntry(32'h0000_1040, 1'b0, 1'b0, 1'b0, 5'd0);
        addEntry(32'h0000_2040, 1'b0, 1'b0, 1'b0, 5'd0);
        addEntry(32'h0010_0000, 1'b0, 1'b0, 1'b0, 5'd0);
        addEntry(32'h000f_fff0, 1'b0, 1'b0, 1'b0, 5'd0);
        addEntry(32'h0000_0000, 1'b0, 1'b0, 1'b0, 5'd0);
        addEntry(32'h0000_0010, 1'b0, 1'b0, 1'b0, 5'd0);
        addEntry(32'h0000_0000, 1'b0, 1'b1, 1'b0, 5'd0);
        addEntry(32'h0000_1040, 1'b1, 1'b0, 1'b0, 5'd0);
        addEntry(32'h0000_0010, 1'b0, 1'b0, 1'b1, 5'd20);
        addEntry(32'h0000_0010, 1'b0, 1'b0, 1'b0, 5'd0);
        addEntry(32'h0000_1040, 1'b0, 1'b0, 1'b0, 5'd0);
        addEntry(32'h0fff_fff0, 1'b0, 1'b0, 1'b0, 5'd0);

        repeat (10) @(negedge clk);
        rst = 1'b0;
        checkResetFlush();

        for (int i = 0; i < numEntries; i++) begin
            if (tblClr[i]) begin
                runClear();
            end
            if (tblHold[i]) begin
                runBurst(tblPc[i]);
            end else if (tblMisp[i]) begin
                runMispredict(tblPc[i], tblMispId[i]);
            end else begin
                runSingle(tblPc[i]);
            end
        end
        finishRun();
    end

endmodule

`default_nettype wire

//--- build.f
verilog/ICachePkg.sv
verilog/ICacheRamIf.sv
verilog/ICacheTagRam.sv
verilog/ICacheDataRam.sv
verilog/FetchFifo.sv
verilog/ICacheTable.sv
verilog/ICacheTop.sv
testbench/ICacheTb.sv
